//--- design/kbd_pkg.sv
package kbd_pkg;

	// Event field widths
	localparam int SCAN_W  = 8;
	localparam int ASCII_W = 8;

	// Prefix tracking in key_event_ctrl
	typedef enum logic [1:0] {
		ST_IDLE,       // No prefix pending
		ST_EXT,        // After E0
		ST_BREAK,      // After F0
		ST_EXT_BREAK   // After E0 F0
	} ctrl_state_e;

	// Set 2 codes the control FSM reacts to
	typedef enum logic [SCAN_W-1:0] {
		SC_EXTEND = 8'hE0,
		SC_BREAK  = 8'hF0,
		SC_LSHIFT = 8'h12,
		SC_RSHIFT = 8'h59,
		SC_CTRL   = 8'h14,  // Right ctrl is E0 14
		SC_ALT    = 8'h11,  // Right alt is E0 11
		SC_CAPS   = 8'h58,
		SC_NUM    = 8'h77,
		SC_SCROLL = 8'h7E
	} scan_op_e;

	// Four-phase host handshake
	typedef enum logic [1:0] {
		OUT_IDLE,      // Ready to capture
		OUT_REQ,       // key_req high, waiting for ack
		OUT_RELEASE    // Waiting for ack to drop
	} out_state_e;

endpackage

//--- design/key_event_if.sv
`timescale 1ns/1ps

interface key_event_if;
	import kbd_pkg::*;

	logic               valid;     // One-cycle strobe
	logic [SCAN_W-1:0]  scan;
	logic               extended;  // Came after E0
	logic               released;  // Came after F0
	logic               shift;     // Shift keys XOR caps lock
	logic               ctrl;
	logic               num_lock;
	logic [ASCII_W-1:0] ascii;     // Zero until the mapper fills it

	// No ready signal, the consumer always takes the event
	modport src (output valid, scan, extended, released, shift, ctrl, num_lock, ascii);
	modport dst (input valid, scan, extended, released, shift, ctrl, num_lock, ascii);

endinterface

//--- design/ps2_frame_rx.sv
`timescale 1ns/1ps

module ps2_frame_rx #(
	parameter int TIMEOUT_BITS = 16
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       ps2_clk,
	input  logic                       ps2_data,
	output logic                       byte_valid,
	output logic [kbd_pkg::SCAN_W-1:0] byte_data,
	output logic                       frame_error
);
	import kbd_pkg::*;

	logic [1:0]              clk_sync;   // [1] is the settled copy
	logic [1:0]              data_sync;
	logic                    clk_prev;
	logic                    fall;       // Falling PS/2 clock edge
	logic [3:0]              bit_cnt;    // Bits received so far
	logic [10:0]             shift_reg;
	logic [10:0]             frame;      // Shift register with the current bit in
	logic [TIMEOUT_BITS-1:0] idle_cnt;
	logic                    frame_ok;

	// Two-flop synchronizers, lines idle high
	always_ff @(posedge clk) begin
		if (reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign fall = clk_prev & ~clk_sync[1];

	// LSB first, so the start bit ends up in [0]
	assign frame    = {data_sync[1], shift_reg[10:1]};
	assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);  // Start, stop, odd parity

	always_ff @(posedge clk) begin
		if (fall)
			shift_reg <= frame;
	end

	always_ff @(posedge clk) begin
		if (fall && bit_cnt == 4'd10)
			byte_data <= frame[SCAN_W:1];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt     <= '0;
			idle_cnt    <= '0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (fall) begin
				idle_cnt <= '0;  // Restart the gap timer on every bit
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					if (frame_ok)
						byte_valid <= 1'b1;
					else
						frame_error <= 1'b1;  // Sticky
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt != '0) begin
				// Stalled mid-frame, drop the partial frame
				if (&idle_cnt) begin
					bit_cnt  <= '0;
					idle_cnt <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	// A frame is 11 PS/2 clocks, so bytes never come back to back
	a_byte_pulse: assert property (@(posedge clk) disable iff (reset)
		byte_valid |=> !byte_valid);

endmodule

//--- design/key_event_ctrl.sv
`timescale 1ns/1ps

module key_event_ctrl (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       byte_valid,
	input  logic [kbd_pkg::SCAN_W-1:0] byte_data,
	key_event_if.src                   ev
);
	import kbd_pkg::*;

	ctrl_state_e state;
	logic        is_prefix;
	logic        in_ext;     // E0 seen for this key
	logic        in_break;   // F0 seen for this key
	logic        make;
	logic        lshift;
	logic        rshift;
	logic        lctrl;
	logic        rctrl;
	logic        lalt;
	logic        ralt;
	logic        caps_lock;
	logic        num_lock;
	logic        scroll_lock;

	assign is_prefix = (byte_data == SC_EXTEND) || (byte_data == SC_BREAK);
	assign in_ext    = (state == ST_EXT) || (state == ST_EXT_BREAK);
	assign in_break  = (state == ST_BREAK) || (state == ST_EXT_BREAK);
	assign make      = !in_break;
	assign ev.ascii  = '0;  // Mapper fills this in

	// Prefix FSM
	always_ff @(posedge clk) begin
		if (reset)
			state <= ST_IDLE;
		else if (byte_valid) begin
			if (byte_data == SC_EXTEND)
				state <= ST_EXT;
			else if (byte_data == SC_BREAK)
				state <= in_ext ? ST_EXT_BREAK : ST_BREAK;
			else
				state <= ST_IDLE;  // Key byte ends the sequence
		end
	end

	// Modifier and lock tracking
	always_ff @(posedge clk) begin
		if (reset) begin
			lshift      <= 1'b0;
			rshift      <= 1'b0;
			lctrl       <= 1'b0;
			rctrl       <= 1'b0;
			lalt        <= 1'b0;
			ralt        <= 1'b0;
			caps_lock   <= 1'b0;
			num_lock    <= 1'b0;
			scroll_lock <= 1'b0;
		end else if (byte_valid && !is_prefix) begin
			case (byte_data)
				SC_LSHIFT: if (!in_ext) lshift <= make;  // Skip fake E0 12
				SC_RSHIFT: if (!in_ext) rshift <= make;
				SC_CTRL: begin
					if (in_ext)
						rctrl <= make;
					else
						lctrl <= make;
				end
				SC_ALT: begin
					if (in_ext)
						ralt <= make;
					else
						lalt <= make;
				end
				// Locks toggle on make only
				SC_CAPS:   if (make && !in_ext) caps_lock <= !caps_lock;
				SC_NUM:    if (make && !in_ext) num_lock <= !num_lock;
				SC_SCROLL: if (make && !in_ext) scroll_lock <= !scroll_lock;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			ev.valid <= 1'b0;
		else
			ev.valid <= byte_valid && !is_prefix;
	end

	// Summary taken before this byte updates the flags
	always_ff @(posedge clk) begin
		if (byte_valid && !is_prefix) begin
			ev.scan     <= byte_data;
			ev.extended <= in_ext;
			ev.released <= in_break;
			ev.shift    <= (lshift | rshift) ^ caps_lock;
			ev.ctrl     <= lctrl | rctrl;
			ev.num_lock <= num_lock;
		end
	end

	a_no_prefix_event: assert property (@(posedge clk) disable iff (reset)
		ev.valid |-> $past(byte_valid) && $past(byte_data) != SC_EXTEND
			&& $past(byte_data) != SC_BREAK);

endmodule

//--- design/scan_ascii_map.sv
`timescale 1ns/1ps

module scan_ascii_map (
	input  logic     clk,
	input  logic     reset,
	key_event_if.dst in_ev,
	key_event_if.src out_ev
);
	import kbd_pkg::*;

	logic [2*ASCII_W-1:0] pair;       // {shifted, plain}
	logic [ASCII_W-1:0]   pad;        // Keypad char under num lock
	logic [ASCII_W-1:0]   code;
	logic                 is_letter;

	// Set 2 lookup
	always_comb begin
		pair = '0;
		pad  = '0;
		case (in_ev.scan)
			8'h16: pair = {8'h21, 8'h31};  // 1 !
			8'h1E: pair = {8'h40, 8'h32};
			8'h26: pair = {8'h23, 8'h33};
			8'h25: pair = {8'h24, 8'h34};
			8'h2E: pair = {8'h25, 8'h35};
			8'h36: pair = {8'h5E, 8'h36};
			8'h3D: pair = {8'h26, 8'h37};
			8'h3E: pair = {8'h2A, 8'h38};
			8'h46: pair = {8'h28, 8'h39};
			8'h45: pair = {8'h29, 8'h30};  // 0 )
			// Letters
			8'h1C: pair = {8'h41, 8'h61};  // a
			8'h32: pair = {8'h42, 8'h62};
			8'h21: pair = {8'h43, 8'h63};
			8'h23: pair = {8'h44, 8'h64};
			8'h24: pair = {8'h45, 8'h65};
			8'h2B: pair = {8'h46, 8'h66};
			8'h34: pair = {8'h47, 8'h67};
			8'h33: pair = {8'h48, 8'h68};
			8'h43: pair = {8'h49, 8'h69};
			8'h3B: pair = {8'h4A, 8'h6A};
			8'h42: pair = {8'h4B, 8'h6B};
			8'h4B: pair = {8'h4C, 8'h6C};
			8'h3A: pair = {8'h4D, 8'h6D};
			8'h31: pair = {8'h4E, 8'h6E};
			8'h44: pair = {8'h4F, 8'h6F};
			8'h4D: pair = {8'h50, 8'h70};
			8'h15: pair = {8'h51, 8'h71};
			8'h2D: pair = {8'h52, 8'h72};
			8'h1B: pair = {8'h53, 8'h73};
			8'h2C: pair = {8'h54, 8'h74};
			8'h3C: pair = {8'h55, 8'h75};
			8'h2A: pair = {8'h56, 8'h76};
			8'h1D: pair = {8'h57, 8'h77};
			8'h22: pair = {8'h58, 8'h78};
			8'h35: pair = {8'h59, 8'h79};
			8'h1A: pair = {8'h5A, 8'h7A};  // z
			// Punctuation
			8'h0E: pair = {8'h7E, 8'h60};  // Backtick, tilde
			8'h4E: pair = {8'h5F, 8'h2D};
			8'h55: pair = {8'h2B, 8'h3D};
			8'h54: pair = {8'h7B, 8'h5B};
			8'h5B: pair = {8'h7D, 8'h5D};
			8'h5D: pair = {8'h7C, 8'h5C};  // Backslash, bar
			8'h4C: pair = {8'h3A, 8'h3B};
			8'h52: pair = {8'h22, 8'h27};
			8'h41: pair = {8'h3C, 8'h2C};
			8'h49: pair = {8'h3E, 8'h2E};
			8'h4A: pair = {8'h3F, 8'h2F};
			// Whitespace and control keys, shift has no effect
			8'h29: pair = {8'h20, 8'h20};  // Space
			8'h66: pair = {8'h08, 8'h08};  // Backspace
			8'h5A: pair = {8'h0D, 8'h0D};  // Enter
			8'h76: pair = {8'h1B, 8'h1B};  // Escape
			8'h0D: pair = {8'h09, 8'h09};  // Tab
			// Keypad operators work without num lock
			8'h7C: pair = {8'h2A, 8'h2A};
			8'h7B: pair = {8'h2D, 8'h2D};
			8'h79: pair = {8'h2B, 8'h2B};
			// Keypad digits and point
			8'h70: pad = 8'h30;
			8'h69: pad = 8'h31;
			8'h72: pad = 8'h32;
			8'h7A: pad = 8'h33;
			8'h6B: pad = 8'h34;
			8'h73: pad = 8'h35;
			8'h74: pad = 8'h36;
			8'h6C: pad = 8'h37;
			8'h75: pad = 8'h38;
			8'h7D: pad = 8'h39;
			8'h71: pad = 8'h2E;
			default: ;
		endcase
	end

	// Only letters have a plain code in 61..7A
	assign is_letter = (pair[ASCII_W-1:0] >= 8'h61) && (pair[ASCII_W-1:0] <= 8'h7A);

	always_comb begin
		if (in_ev.released || in_ev.extended)
			code = '0;
		else if (is_letter && in_ev.ctrl)
			code = pair[ASCII_W-1:0] - 8'h60;  // Ctrl-A is 01, ignores shift
		else if (pad != '0)
			code = in_ev.num_lock ? pad : '0;
		else
			code = in_ev.shift ? pair[2*ASCII_W-1:ASCII_W] : pair[ASCII_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_ev.valid <= 1'b0;
		else
			out_ev.valid <= in_ev.valid;
	end

	always_ff @(posedge clk) begin
		if (in_ev.valid) begin
			out_ev.scan     <= in_ev.scan;
			out_ev.extended <= in_ev.extended;
			out_ev.released <= in_ev.released;
			out_ev.shift    <= in_ev.shift;
			out_ev.ctrl     <= in_ev.ctrl;
			out_ev.num_lock <= in_ev.num_lock;
			out_ev.ascii    <= code;
		end
	end

endmodule

//--- design/key_event_out.sv
`timescale 1ns/1ps

module key_event_out (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        key_ack,
	key_event_if.dst                    ev,
	output logic                        key_req,
	output logic [kbd_pkg::SCAN_W-1:0]  key_scan,
	output logic [kbd_pkg::ASCII_W-1:0] key_ascii,
	output logic                        key_extended,
	output logic                        key_released,
	output logic                        overrun
);
	import kbd_pkg::*;

	out_state_e state;

	assign key_req = (state == OUT_REQ);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= OUT_IDLE;
			overrun <= 1'b0;
		end else begin
			case (state)
				OUT_IDLE:    if (ev.valid) state <= OUT_REQ;
				OUT_REQ:     if (key_ack) state <= OUT_RELEASE;   // Drop req next cycle
				OUT_RELEASE: if (!key_ack) state <= OUT_IDLE;     // Host finished
				default:     state <= OUT_IDLE;
			endcase
			// Busy, the new event is lost
			if (ev.valid && state != OUT_IDLE)
				overrun <= 1'b1;
		end
	end

	// Held event, only loaded when idle
	always_ff @(posedge clk) begin
		if (ev.valid && state == OUT_IDLE) begin
			key_scan     <= ev.scan;
			key_ascii    <= ev.ascii;
			key_extended <= ev.extended;
			key_released <= ev.released;
		end
	end

	a_data_stable: assert property (@(posedge clk) disable iff (reset)
		key_req && $past(key_req) |->
			$stable({key_scan, key_ascii, key_extended, key_released}));

endmodule

//--- design/ps2_keyboard_top.sv
`timescale 1ns/1ps

module ps2_keyboard_top #(
	parameter int TIMEOUT_BITS = 16  // About 1.3 ms at 50 MHz
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        ps2_clk,
	input  logic                        ps2_data,
	input  logic                        key_ack,
	output logic                        key_req,
	output logic [kbd_pkg::SCAN_W-1:0]  key_scan,
	output logic [kbd_pkg::ASCII_W-1:0] key_ascii,
	output logic                        key_extended,
	output logic                        key_released,
	output logic                        frame_error,
	output logic                        overrun
);
	import kbd_pkg::*;

	logic              byte_valid;
	logic [SCAN_W-1:0] byte_data;

	key_event_if ev_raw ();  // Control to mapper
	key_event_if ev_map ();  // Mapper to host stage

	ps2_frame_rx #(
		.TIMEOUT_BITS (TIMEOUT_BITS)
	) ps2_frame_rx_i (
		.clk         (clk),
		.reset       (reset),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.frame_error (frame_error)
	);

	key_event_ctrl key_event_ctrl_i (
		.clk        (clk),
		.reset      (reset),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.ev         (ev_raw.src)
	);

	scan_ascii_map scan_ascii_map_i (
		.clk    (clk),
		.reset  (reset),
		.in_ev  (ev_raw.dst),
		.out_ev (ev_map.src)
	);

	key_event_out key_event_out_i (
		.clk          (clk),
		.reset        (reset),
		.key_ack      (key_ack),
		.ev           (ev_map.dst),
		.key_req      (key_req),
		.key_scan     (key_scan),
		.key_ascii    (key_ascii),
		.key_extended (key_extended),
		.key_released (key_released),
		.overrun      (overrun)
	);

endmodule

//--- tb/ps2_keyboard_tb.sv
`timescale 1ns/1ps

module ps2_keyboard_tb;

	localparam int HALF_PERIOD  = 20;                // PS/2 clock half-period in clk cycles
	localparam int FRAME_CYCLES = 23 * HALF_PERIOD;  // 11 bits plus idle tail
	localparam int NUM_FRAMES   = 35;                // Frames sent over all tests
	// Doubled for margin, six extra frames cover the quiet windows and the stall gap
	localparam int WATCHDOG_CYCLES = 2 * (NUM_FRAMES + 6) * FRAME_CYCLES;

	logic       clk;
	logic       reset;
	logic       ps2_clk;
	logic       ps2_data;
	logic       key_ack;
	logic       key_req;
	logic [7:0] key_scan;
	logic [7:0] key_ascii;
	logic       key_extended;
	logic       key_released;
	logic       frame_error;
	logic       overrun;
	int         errors;

	ps2_keyboard_top #(
		.TIMEOUT_BITS (10)  // Short gap timeout for the stalled-frame test
	) ps2_keyboard_top_i (
		.clk          (clk),
		.reset        (reset),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data),
		.key_ack      (key_ack),
		.key_req      (key_req),
		.key_scan     (key_scan),
		.key_ascii    (key_ascii),
		.key_extended (key_extended),
		.key_released (key_released),
		.frame_error  (frame_error),
		.overrun      (overrun)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends at posedge plus 1 ns, where all drives happen
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic check(input logic [7:0] actual, input logic [7:0] expected,
		input string what);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
		end
	endtask

	// Keyboard side, data changes while the PS/2 clock is high
	task automatic send_bits(input logic [10:0] frame, input int nbits);
		for (int i = 0; i < nbits; i++) begin
			ps2_data = frame[i];  // LSB first
			wait_cycles(HALF_PERIOD);
			ps2_clk = 1'b0;  // Receiver samples here
			wait_cycles(HALF_PERIOD);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;  // Bus idles high
	endtask

	task automatic send_byte(input logic [7:0] data, input logic bad_parity = 1'b0);
		logic        parity;
		logic [10:0] frame;
		parity = ~^data;  // Odd parity over the data bits
		if (bad_parity)
			parity = ~parity;
		frame = {1'b1, parity, data, 1'b0};  // Stop, parity, data, start
		send_bits(frame, 11);
		wait_cycles(HALF_PERIOD);
	endtask

	task automatic wait_req(output logic seen);
		int cnt;
		cnt = 0;
		while (!key_req && cnt < 2 * FRAME_CYCLES) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		seen = key_req;
	endtask

	// Host side of the four-phase handshake
	task automatic complete_handshake();
		int cnt;
		key_ack = 1'b1;
		cnt = 0;
		while (key_req && cnt < 100) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (key_req) begin
			errors++;
			$display("Error at %0t: key_req stayed high after key_ack rose", $time);
		end
		key_ack = 1'b0;
		wait_cycles(2);  // Stage back in OUT_IDLE
	endtask

	task automatic expect_event(input logic [7:0] scan, input logic [7:0] ascii,
		input logic ext, input logic rel);
		logic seen;
		wait_req(seen);
		if (!seen) begin
			errors++;
			$display("Error at %0t: no key_req for scan code %h", $time, scan);
		end else begin
			check(key_scan, scan, $sformatf("key_scan for %h", scan));
			check(key_ascii, ascii, $sformatf("key_ascii for %h", scan));
			check(8'(key_extended), 8'(ext), $sformatf("key_extended for %h", scan));
			check(8'(key_released), 8'(rel), $sformatf("key_released for %h", scan));
			complete_handshake();
		end
	endtask

	task automatic expect_quiet(input int n, input string what);
		logic saw;
		saw = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#1;
			if (key_req)
				saw = 1'b1;
		end
		check(8'(saw), 8'd0, what);
	endtask

	task automatic make_break_letter();
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h61, 1'b0, 1'b0);  // a
		send_byte(8'hF0);
		check(8'(key_req), 8'd0, "key_req after F0 prefix");
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h00, 1'b0, 1'b1);  // Break carries no ASCII
	endtask

	task automatic shift_and_caps();
		send_byte(8'h12);
		expect_event(8'h12, 8'h00, 1'b0, 1'b0);  // Shift itself is unmapped
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h41, 1'b0, 1'b0);  // A
		send_byte(8'hF0);
		send_byte(8'h12);
		expect_event(8'h12, 8'h00, 1'b0, 1'b1);
		send_byte(8'h58);
		expect_event(8'h58, 8'h00, 1'b0, 1'b0);  // Caps on
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h41, 1'b0, 1'b0);
		send_byte(8'h12);
		expect_event(8'h12, 8'h00, 1'b0, 1'b0);
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h61, 1'b0, 1'b0);  // Caps and shift cancel
		send_byte(8'hF0);
		send_byte(8'h12);
		expect_event(8'h12, 8'h00, 1'b0, 1'b1);
		send_byte(8'h58);
		expect_event(8'h58, 8'h00, 1'b0, 1'b0);  // Caps off again
	endtask

	task automatic extended_and_ctrl();
		send_byte(8'hE0);
		send_byte(8'h74);
		expect_event(8'h74, 8'h00, 1'b1, 1'b0);  // Right arrow
		send_byte(8'h14);
		expect_event(8'h14, 8'h00, 1'b0, 1'b0);  // Left ctrl down
		send_byte(8'h21);
		expect_event(8'h21, 8'h03, 1'b0, 1'b0);  // Ctrl-C
		send_byte(8'hF0);
		send_byte(8'h14);
		expect_event(8'h14, 8'h00, 1'b0, 1'b1);
		send_byte(8'hE0);
		send_byte(8'h14);
		expect_event(8'h14, 8'h00, 1'b1, 1'b0);  // Right ctrl down
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h01, 1'b0, 1'b0);  // Ctrl-A
		send_byte(8'hE0);
		send_byte(8'hF0);
		send_byte(8'h14);
		expect_event(8'h14, 8'h00, 1'b1, 1'b1);
		send_byte(8'h21);
		expect_event(8'h21, 8'h63, 1'b0, 1'b0);  // Plain c
	endtask

	task automatic number_pad();
		send_byte(8'h69);
		expect_event(8'h69, 8'h00, 1'b0, 1'b0);  // Num lock off
		send_byte(8'h77);
		expect_event(8'h77, 8'h00, 1'b0, 1'b0);
		send_byte(8'h69);
		expect_event(8'h69, 8'h31, 1'b0, 1'b0);  // Keypad 1
	endtask

	task automatic bad_frames();
		logic [10:0] partial;
		check(8'(frame_error), 8'd0, "frame_error before bad frame");
		send_byte(8'h1C, 1'b1);
		expect_quiet(2 * FRAME_CYCLES, "key_req after bad parity frame");
		check(8'(frame_error), 8'd1, "frame_error after bad parity");
		partial = {2'b11, 8'h1C, 1'b0};  // Only the first five bits go out
		send_bits(partial, 5);
		wait_cycles(1200);  // Longer than the 2^10 gap timeout
		send_byte(8'h1C);
		expect_event(8'h1C, 8'h61, 1'b0, 1'b0);
	endtask

	task automatic back_pressure();
		logic seen;
		check(8'(overrun), 8'd0, "overrun before back-pressure");
		send_byte(8'h1C);
		wait_req(seen);
		check(8'(seen), 8'd1, "key_req for held 1C");
		send_byte(8'h32);  // Host still holding off
		check(key_scan, 8'h1C, "key_scan while busy");
		check(key_ascii, 8'h61, "key_ascii while busy");
		check(8'(overrun), 8'd1, "overrun after dropped event");
		check(8'(key_req), 8'd1, "key_req while busy");
		complete_handshake();
		expect_quiet(FRAME_CYCLES, "key_req for dropped 32");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		errors   = 0;
		reset    = 1'b1;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		key_ack  = 1'b0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		wait_cycles(5);
		make_break_letter();
		shift_and_caps();
		extended_and_ctrl();
		number_pad();
		bad_frames();
		back_pressure();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- build.f
design/kbd_pkg.sv
design/key_event_if.sv
design/ps2_frame_rx.sv
design/key_event_ctrl.sv
design/scan_ascii_map.sv
design/key_event_out.sv
design/ps2_keyboard_top.sv
tb/ps2_keyboard_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the PS/2 keyboard testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f build.f \
	--top-module ps2_keyboard_tb \
	-o ps2_keyboard_sim

./obj_dir/ps2_keyboard_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "Testbench reported failure"
	exit 1
fi
echo "Testbench run clean"
